/* common/riscv_m_pkg.sv */
// Encodings follow the RV32M funct3 field of the OP major opcode and nothing else is decoded
`default_nettype none

package riscv_m_pkg;

	// Width of the funct3 field in the R-type format
	localparam int FUNCT3_W = 3;

	// M-extension operations by funct3
	typedef enum logic [FUNCT3_W-1:0] {
		MUL    = 3'd0, // Low word, sign does not matter
		MULH   = 3'd1, // High word, signed x signed
		MULHSU = 3'd2, // High word, signed x unsigned
		MULHU  = 3'd3, // High word, unsigned x unsigned
		DIV    = 3'd4,
		DIVU   = 3'd5,
		REM    = 3'd6, // Sign follows the dividend
		REMU   = 3'd7
	} m_op_e;

endpackage

`default_nettype wire

/* common/mdu_pkg.sv */
// Internal control types of the multiply/divide unit and never seen at the top-level ports
`default_nettype none

package mdu_pkg;

	// Which engine runs the operation in flight
	typedef enum logic {
		ENG_MUL = 1'b0,
		ENG_DIV = 1'b1
	} engine_e;

	// Per-operation control for either engine
	typedef struct packed {
		logic sign_a; // Operand A is two's complement
		logic sign_b; // Operand B is two's complement
		logic sel_hi; // High word or remainder
	} mdu_ctrl_t;

endpackage

`default_nettype wire

/* common/mdu_req_if.sv */
// One issued operation with a single-cycle go strobe and no back-pressure from the engine
`timescale 1ns/1ps
`default_nettype none

interface mdu_req_if #(
	parameter int XLEN = 32
) ();
	logic                go;   // One-cycle pulse, operands valid with it
	mdu_pkg::mdu_ctrl_t  ctrl;
	logic [XLEN-1:0]     op_a;
	logic [XLEN-1:0]     op_b;

	modport issuer (output go, output ctrl, output op_a, output op_b);
	modport engine (input go, input ctrl, input op_a, input op_b);

endinterface

`default_nettype wire

/* hw/mdu/mdu_issue.sv */
// One operation in flight at a time and a start strobe seen while busy is dropped
`timescale 1ns/1ps
`default_nettype none

module mdu_issue #(
	parameter int XLEN = 32
) (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  logic                             start_i,
	input  logic [riscv_m_pkg::FUNCT3_W-1:0] funct3_i,
	input  logic [XLEN-1:0]                  op_a_i,
	input  logic [XLEN-1:0]                  op_b_i,
	input  logic                             done_i,
	output logic                             busy_o,
	mdu_req_if.issuer                        mul_o,
	mdu_req_if.issuer                        div_o,
	output mdu_pkg::engine_e                 eng_o
);
	riscv_m_pkg::m_op_e op;
	mdu_pkg::engine_e   eng_d;
	mdu_pkg::engine_e   eng_q;
	mdu_pkg::mdu_ctrl_t ctrl_d;
	mdu_pkg::mdu_ctrl_t ctrl_q;
	logic               accept;
	logic               busy_q;
	logic               issue_q;
	logic               mul_go_q;
	logic               div_go_q;
	logic [XLEN-1:0]    op_a_q;
	logic [XLEN-1:0]    op_b_q;

	assign op     = riscv_m_pkg::m_op_e'(funct3_i);
	assign busy_o = busy_q & ~done_i; // Falls with the done pulse
	assign accept = start_i & ~busy_o;

	always_comb begin
		eng_d         = (op inside {riscv_m_pkg::DIV, riscv_m_pkg::DIVU,
			riscv_m_pkg::REM, riscv_m_pkg::REMU}) ? mdu_pkg::ENG_DIV : mdu_pkg::ENG_MUL;
		ctrl_d.sign_a = op inside {riscv_m_pkg::MULH, riscv_m_pkg::MULHSU,
			riscv_m_pkg::DIV, riscv_m_pkg::REM};
		ctrl_d.sign_b = op inside {riscv_m_pkg::MULH, riscv_m_pkg::DIV, riscv_m_pkg::REM};
		ctrl_d.sel_hi = op inside {riscv_m_pkg::MULH, riscv_m_pkg::MULHSU,
			riscv_m_pkg::MULHU, riscv_m_pkg::REM, riscv_m_pkg::REMU};
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q   <= 1'b0;
			issue_q  <= 1'b0;
			mul_go_q <= 1'b0;
			div_go_q <= 1'b0;
			eng_q    <= mdu_pkg::ENG_MUL;
		end else begin
			issue_q  <= accept;
			mul_go_q <= issue_q & (eng_q == mdu_pkg::ENG_MUL);
			div_go_q <= issue_q & (eng_q == mdu_pkg::ENG_DIV);
			if (accept) begin
				busy_q <= 1'b1;
				eng_q  <= eng_d;
			end else if (done_i) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_a_q <= op_a_i;
			op_b_q <= op_b_i;
			ctrl_q <= ctrl_d;
		end
	end

	// Both engines see the same operands, only go differs
	assign mul_o.go   = mul_go_q;
	assign mul_o.ctrl = ctrl_q;
	assign mul_o.op_a = op_a_q;
	assign mul_o.op_b = op_b_q;
	assign div_o.go   = div_go_q;
	assign div_o.ctrl = ctrl_q;
	assign div_o.op_a = op_a_q;
	assign div_o.op_b = op_b_q;
	assign eng_o      = eng_q;

endmodule

`default_nettype wire

/* hw/mdu/mdu_multiplier.sv */
// Two register stages with no stall and a new operation may enter on every cycle
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier #(
	parameter int XLEN = 32
) (
	input  logic            clk_i,
	input  logic            rst_i,
	mdu_req_if.engine       req_i,
	output logic            done_o,
	output logic [XLEN-1:0] value_o
);
	logic signed [XLEN:0]     a_ext;
	logic signed [XLEN:0]     b_ext;
	logic signed [2*XLEN+1:0] prod;
	logic [2*XLEN+1:0]        prod_q;
	logic                     valid_q;
	logic                     sel_hi_q;

	// One extra bit makes every mix a signed multiply
	assign a_ext = {req_i.ctrl.sign_a & req_i.op_a[XLEN-1], req_i.op_a};
	assign b_ext = {req_i.ctrl.sign_b & req_i.op_b[XLEN-1], req_i.op_b};
	assign prod  = (2*XLEN+2)'(a_ext) * (2*XLEN+2)'(b_ext);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			valid_q <= req_i.go;
			done_o  <= valid_q;
		end
	end

	always_ff @(posedge clk_i) begin
		prod_q   <= prod;
		sel_hi_q <= req_i.ctrl.sel_hi;
		if (sel_hi_q) begin
			value_o <= prod_q[2*XLEN-1:XLEN];
		end else begin
			value_o <= prod_q[XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

/* hw/mdu/mdu_divider.sv */
// Fixed XLEN+2 cycles from go to done and a go while an operation runs restarts the engine
`timescale 1ns/1ps
`default_nettype none

module mdu_divider #(
	parameter int XLEN = 32
) (
	input  logic            clk_i,
	input  logic            rst_i,
	mdu_req_if.engine       req_i,
	output logic            done_o,
	output logic [XLEN-1:0] value_o
);
	logic [XLEN:0]   cyc_q; // One-hot, top bit is the fix-up step
	logic [XLEN-1:0] divisor_q;
	logic [XLEN-1:0] quo_q; // Dividend shifts out as quotient shifts in
	logic [XLEN-1:0] rem_q;
	logic            neg_a_q;
	logic            neg_b_q;
	logic            sel_rem_q;
	logic            neg_a;
	logic            neg_b;
	logic [XLEN+1:0] shifted;
	logic [XLEN+1:0] diff;
	logic [XLEN-1:0] quo_fix;
	logic [XLEN-1:0] rem_fix;

	assign neg_a = req_i.ctrl.sign_a & req_i.op_a[XLEN-1];
	assign neg_b = req_i.ctrl.sign_b & req_i.op_b[XLEN-1];

	// Extra top bit keeps large unsigned divisors from wrapping
	assign shifted = {1'b0, rem_q, quo_q[XLEN-1]};
	assign diff    = shifted - {2'b00, divisor_q};

	// Divide by zero keeps the all-ones quotient unsigned
	assign quo_fix = ((neg_a_q ^ neg_b_q) && (divisor_q != '0)) ? -quo_q : quo_q;
	assign rem_fix = neg_a_q ? -rem_q : rem_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cyc_q  <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= cyc_q[XLEN];
			if (req_i.go) begin
				cyc_q <= {{XLEN{1'b0}}, 1'b1};
			end else begin
				cyc_q <= cyc_q << 1; // Fix-up bit falls off the end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i.go) begin
			divisor_q <= neg_b ? -req_i.op_b : req_i.op_b;
			quo_q     <= neg_a ? -req_i.op_a : req_i.op_a;
			rem_q     <= '0;
			neg_a_q   <= neg_a;
			neg_b_q   <= neg_b;
			sel_rem_q <= req_i.ctrl.sel_hi;
		end else if (cyc_q[XLEN-1:0] != '0) begin
			quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN+1]};
			if (diff[XLEN+1]) begin
				rem_q <= shifted[XLEN-1:0]; // Restore
			end else begin
				rem_q <= diff[XLEN-1:0];
			end
		end

		if (cyc_q[XLEN]) begin
			value_o <= sel_rem_q ? rem_fix : quo_fix;
		end
	end

endmodule

`default_nettype wire

/* hw/mdu/mdu_result.sv */
// Only the engine named by eng_i is listened to and a done from the other engine is ignored
`timescale 1ns/1ps
`default_nettype none

module mdu_result #(
	parameter int XLEN = 32
) (
	input  logic             clk_i,
	input  logic             rst_i,
	input  mdu_pkg::engine_e eng_i,
	input  logic             mul_done_i,
	input  logic [XLEN-1:0]  mul_value_i,
	input  logic             div_done_i,
	input  logic [XLEN-1:0]  div_value_i,
	output logic             done_o,
	output logic [XLEN-1:0]  result_o
);
	logic mul_hit;
	logic div_hit;

	assign mul_hit = mul_done_i & (eng_i == mdu_pkg::ENG_MUL);
	assign div_hit = div_done_i & (eng_i == mdu_pkg::ENG_DIV);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= mul_hit | div_hit;
		end
	end

	// Holds until the next completion
	always_ff @(posedge clk_i) begin
		if (mul_hit) begin
			result_o <= mul_value_i;
		end else if (div_hit) begin
			result_o <= div_value_i;
		end
	end

endmodule

`default_nettype wire

/* hw/mdu_top.sv */
// Multiply done 4 cycles and divide done 36 cycles after start is accepted
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
	parameter int XLEN = 32
) (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  logic                             start_i,
	input  logic [riscv_m_pkg::FUNCT3_W-1:0] funct3_i,
	input  logic [XLEN-1:0]                  op_a_i,
	input  logic [XLEN-1:0]                  op_b_i,
	output logic                             busy_o,
	output logic                             done_o,
	output logic [XLEN-1:0]                  result_o
);
	mdu_pkg::engine_e eng;
	logic             mul_done;
	logic [XLEN-1:0]  mul_value;
	logic             div_done;
	logic [XLEN-1:0]  div_value;

	mdu_req_if #(.XLEN(XLEN)) mul_req ();
	mdu_req_if #(.XLEN(XLEN)) div_req ();

	mdu_issue #(.XLEN(XLEN)) u_issue (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.start_i  (start_i),
		.funct3_i (funct3_i),
		.op_a_i   (op_a_i),
		.op_b_i   (op_b_i),
		.done_i   (done_o), // Ends busy
		.busy_o   (busy_o),
		.mul_o    (mul_req.issuer),
		.div_o    (div_req.issuer),
		.eng_o    (eng)
	);

	mdu_multiplier #(.XLEN(XLEN)) u_mul (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (mul_req.engine),
		.done_o  (mul_done),
		.value_o (mul_value)
	);

	mdu_divider #(.XLEN(XLEN)) u_div (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (div_req.engine),
		.done_o  (div_done),
		.value_o (div_value)
	);

	mdu_result #(.XLEN(XLEN)) u_result (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.eng_i       (eng),
		.mul_done_i  (mul_done),
		.mul_value_i (mul_value),
		.div_done_i  (div_done),
		.div_value_i (div_value),
		.done_o      (done_o),
		.result_o    (result_o)
	);

endmodule

`default_nettype wire

/* tests/tb_mdu.sv */
// Runs at XLEN of 32 only and expects fixed latencies of 4 cycles for multiply and 36 for divide
`timescale 1ns/1ps
`default_nettype none

module tb_mdu;
	localparam int XLEN            = 32;
	localparam int RAND_OPS        = 200;
	localparam int CORNER_OPS      = 48;
	localparam int NUM_OPS         = 2 * RAND_OPS + CORNER_OPS + 2;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 100;
	localparam int MUL_LAT         = 4;
	localparam int DIV_LAT         = 36;
	localparam int DONE_WAIT       = 60; // Per-operation limit
	localparam logic [31:0] LFSR_MASK = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	logic              clk;
	logic              rst;
	logic              start;
	logic [2:0]        funct3;
	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;
	logic              busy;
	logic              done;
	logic [XLEN-1:0]   result;
	logic [31:0]       lfsr_q = 32'd54;
	int                checks = 0;
	int                errors = 0;

	mdu_top #(.XLEN(XLEN)) UUT (
		.clk_i    (clk),
		.rst_i    (rst),
		.start_i  (start),
		.funct3_i (funct3),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.busy_o   (busy),
		.done_o   (done),
		.result_o (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val    = {val[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_MASK) : (lfsr_q >> 1);
		end
		return val;
	endfunction

	// RV32M rules including divide by zero and signed overflow
	function automatic logic [31:0] model_result(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] mulss;
		logic [63:0] mulsu;
		logic [63:0] muluu;
		int          qa;
		int          qb;
		int          sq;
		int          sr;
		logic        ovf;
		logic [31:0] res;
		sa    = {{32{a[31]}}, a};
		sb    = {{32{b[31]}}, b};
		ua    = {32'b0, a};
		ub    = {32'b0, b};
		mulss = sa * sb;
		mulsu = sa * ub;
		muluu = ua * ub;
		qa    = a;
		qb    = b;
		ovf   = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		if (b == '0) begin
			sq = -1;
			sr = qa;
		end else if (ovf) begin
			sq = qa; // Most negative value
			sr = 0;
		end else begin
			sq = qa / qb; // Truncates toward zero
			sr = qa % qb;
		end
		case (riscv_m_pkg::m_op_e'(f3))
			riscv_m_pkg::MUL:    res = mulss[31:0];
			riscv_m_pkg::MULH:   res = mulss[63:32];
			riscv_m_pkg::MULHSU: res = mulsu[63:32];
			riscv_m_pkg::MULHU:  res = muluu[63:32];
			riscv_m_pkg::DIV:    res = sq;
			riscv_m_pkg::DIVU:   res = (b == '0) ? '1 : a / b;
			riscv_m_pkg::REM:    res = sr;
			riscv_m_pkg::REMU:   res = (b == '0) ? a : a % b;
			default:             res = '0;
		endcase
		return res;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	task automatic run_op(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] exp;
		int          lat;
		int          cycles;
		exp    = model_result(f3, a, b);
		lat    = f3[2] ? DIV_LAT : MUL_LAT;
		start  = 1'b1;
		funct3 = f3;
		op_a   = a;
		op_b   = b;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_bit("busy_o", busy, 1'b1);
		cycles = 0;
		while (!done && cycles < DONE_WAIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		checks++;
		assert (done) else begin
			errors++;
			$display("At %0t done_o never rose within %0d cycles of start", $time, DONE_WAIT);
		end
		if (done) begin
			check_word("done_o latency", cycles, lat);
			check_word("result_o", result, exp);
			check_bit("busy_o", busy, 1'b0); // Falls with done
			@(posedge clk);
			#1;
			check_bit("done_o", done, 1'b0);
		end
	endtask

	task automatic run_random(input logic div_ops);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		int          n;
		for (n = 0; n < RAND_OPS; n++) begin
			r = rand_bits(2);
			a = rand_bits(32);
			b = rand_bits(32);
			if (div_ops) begin
				b = b >> rand_bits(5); // Spread divisor sizes
			end
			run_op({div_ops, r[1:0]}, a, b);
		end
	endtask

	task automatic run_corners;
		logic [31:0] vals [3];
		int          i;
		int          j;
		int          k;
		vals = '{32'd0, 32'd1, 32'hFFFF_FFFF};
		for (k = 4; k < 8; k++) begin
			run_op(k[2:0], 32'h1234_5678, 32'd0);
			run_op(k[2:0], 32'hFFFF_FFF9, 32'd0);
			run_op(k[2:0], 32'h8000_0000, 32'hFFFF_FFFF);
		end
		for (k = 0; k < 4; k++) begin
			for (i = 0; i < 3; i++) begin
				for (j = 0; j < 3; j++) begin
					run_op(k[2:0], vals[i], vals[j]);
				end
			end
		end
	endtask

	task automatic run_ignored_start;
		logic [31:0] exp;
		logic [31:0] got;
		int          dones;
		int          n;
		exp    = model_result(riscv_m_pkg::REM, 32'hFFFF_FF85, 32'd10);
		got    = '0;
		dones  = 0;
		start  = 1'b1;
		funct3 = riscv_m_pkg::REM;
		op_a   = 32'hFFFF_FF85;
		op_b   = 32'd10;
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (5) begin
			@(posedge clk);
			#1;
		end
		check_bit("busy_o", busy, 1'b1);
		start  = 1'b1; // A multiply here would finish first if taken
		funct3 = riscv_m_pkg::MUL;
		op_a   = 32'd3;
		op_b   = 32'd5;
		@(posedge clk);
		#1;
		start = 1'b0;
		for (n = 0; n < 60; n++) begin
			if (done) begin
				dones++;
				got = result;
			end
			@(posedge clk);
			#1;
		end
		check_word("done_o pulse count", dones, 32'd1);
		check_word("result_o", got, exp);
	endtask

	initial begin
		int c0;
		int e0;
		rst    = 1'b1;
		start  = 1'b0;
		funct3 = '0;
		op_a   = '0;
		op_b   = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		c0  = checks;
		e0  = errors;
		repeat (5) begin
			check_bit("busy_o", busy, 1'b0);
			check_bit("done_o", done, 1'b0);
			@(posedge clk);
			#1;
		end
		report_test("reset and idle", c0, e0);
		c0 = checks;
		e0 = errors;
		run_random(1'b0);
		report_test("random multiply", c0, e0);
		c0 = checks;
		e0 = errors;
		run_random(1'b1);
		report_test("random divide", c0, e0);
		c0 = checks;
		e0 = errors;
		run_corners();
		report_test("corner cases", c0, e0);
		c0 = checks;
		e0 = errors;
		run_ignored_start();
		report_test("start while busy", c0, e0);
		$display("Totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
common/riscv_m_pkg.sv
common/mdu_pkg.sv
common/mdu_req_if.sv
hw/mdu/mdu_issue.sv
hw/mdu/mdu_multiplier.sv
hw/mdu/mdu_divider.sv
hw/mdu/mdu_result.sv
hw/mdu_top.sv
tests/tb_mdu.sv

/* Makefile */
# Verilator flow for the multiply/divide unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module mdu_top

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_mdu -o tb_mdu
	@out="$$(./obj_dir/tb_mdu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
